/* Bender.yml */
package:
  name: rvvi_trace

sources:
  # Design, in compile order
  - rtl/trace_pkg.sv
  - rtl/retire_if.sv
  - rtl/trace_ctrl.sv
  - rtl/reg_wb_expand.sv
  - rtl/csr_wb_map.sv
  - rtl/rvvi_trace_top.sv

  # Testbench
  - target: simulation
    files:
      - verification/tb_rvvi_trace.sv

/* list.f */
rtl/trace_pkg.sv
rtl/retire_if.sv
rtl/trace_ctrl.sv
rtl/reg_wb_expand.sv
rtl/csr_wb_map.sv
rtl/rvvi_trace_top.sv
verification/tb_rvvi_trace.sv

/* rtl/csr_wb_map.sv */
`timescale 1ns/1ns

module csr_wb_map (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  fire_i,
    retire_if.dp                  ret_i,
    output trace_pkg::csr_flags_t csr_wb_o,
    output trace_pkg::xlen_t      csr_wdata_o,
    output trace_pkg::xlen_t      mstatus_wdata_o,
    output trace_pkg::xlen_t      insn_o,
    output logic                  trap_o,
    output trace_pkg::xlen_t      pc_rdata_o,
    output trace_pkg::xlen_t      pc_wdata_o
);
    import trace_pkg::*;

    csr_addr_t  csr_addr;
    csr_flags_t csr_hit;
    logic       other_hit;
    csr_flags_t csr_wb_q;
    xlen_t      csr_wdata_q;
    xlen_t      mstatus_wdata_q;
    xlen_t      insn_q;
    logic       trap_q;
    xlen_t      pc_rdata_q;
    xlen_t      pc_wdata_q;

    // CSR address from the I-type immediate field
    assign csr_addr = ret_i.insn[31:20];

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    always_comb begin
        csr_hit = '0;
        if (ret_i.csr_wen) begin
            case (csr_addr)
                CSR_MISA:      csr_hit[IDX_MISA]      = 1'b1;
                CSR_MIE:       csr_hit[IDX_MIE]       = 1'b1;
                CSR_MTVEC:     csr_hit[IDX_MTVEC]     = 1'b1;
                CSR_MEPC:      csr_hit[IDX_MEPC]      = 1'b1;
                CSR_MCAUSE:    csr_hit[IDX_MCAUSE]    = 1'b1;
                CSR_MVENDORID: csr_hit[IDX_MVENDORID] = 1'b1;
                CSR_MARCHID:   csr_hit[IDX_MARCHID]   = 1'b1;
                CSR_MIMPID:    csr_hit[IDX_MIMPID]    = 1'b1;
                CSR_MHARTID:   csr_hit[IDX_MHARTID]   = 1'b1;
                // mstatus and untracked addresses
                default:       csr_hit = '0;
            endcase
        end
        // mstatus changes come from the mask, not the instruction
        if (ret_i.mstatus_wmask != '0) begin
            csr_hit[IDX_MSTATUS] = 1'b1;
        end
    end

    assign other_hit = |csr_hit[NUM_TRACKED_CSR-1:1];

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            csr_wb_q <= '0;
        end else begin
            csr_wb_q <= fire_i ? csr_hit : '0;
        end
    end

    // Write data only alongside its flag
    always_ff @(posedge clk_i) begin
        csr_wdata_q     <= (fire_i && other_hit) ? ret_i.csr_wdata : '0;
        mstatus_wdata_q <= (fire_i && csr_hit[IDX_MSTATUS]) ? ret_i.mstatus_wdata : '0;
    end

    // Pass-through fields, held between fires
    always_ff @(posedge clk_i) begin
        if (fire_i) begin
            insn_q     <= ret_i.insn;
            trap_q     <= ret_i.trap;
            pc_rdata_q <= ret_i.pc_rdata;
            pc_wdata_q <= ret_i.pc_wdata;
        end
    end

    assign csr_wb_o        = csr_wb_q;
    assign csr_wdata_o     = csr_wdata_q;
    assign mstatus_wdata_o = mstatus_wdata_q;
    assign insn_o          = insn_q;
    assign trap_o          = trap_q;
    assign pc_rdata_o      = pc_rdata_q;
    assign pc_wdata_o      = pc_wdata_q;

    // One instruction CSR plus possibly mstatus
    a_csr_wb_limit: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(csr_wb_o[NUM_TRACKED_CSR-1:1]));

endmodule

/* rtl/reg_wb_expand.sv */
`timescale 1ns/1ns

module reg_wb_expand #(
    parameter bit SKIP_ZERO = 1'b1
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                fire_i,
    input  logic                wen_i,
    input  trace_pkg::reg_addr_t addr_i,
    input  trace_pkg::xlen_t     wdata_i,
    output trace_pkg::reg_flags_t wb_o,
    output trace_pkg::xlen_t     wdata_o
);
    import trace_pkg::*;

    logic       addr_zero;
    logic       wb_hit;
    reg_flags_t wb_onehot;
    reg_flags_t wb_q;
    xlen_t      wdata_q;

    // x0 writes are not architectural, f0 is a real register
    assign addr_zero = (addr_i == '0);
    assign wb_hit    = fire_i && wen_i && !(SKIP_ZERO && addr_zero);

    // Decode index to one-hot
    assign wb_onehot = reg_flags_t'(1) << addr_i;

    // Flag register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_hit ? wb_onehot : '0;
        end
    end

    // Data word, cleared in cycles without a write
    always_ff @(posedge clk_i) begin
        wdata_q <= wb_hit ? wdata_i : '0;
    end

    assign wb_o    = wb_q;
    assign wdata_o = wdata_q;

    // At most one register written per retirement
    a_wb_onehot0: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(wb_o));

endmodule

/* rtl/retire_if.sv */
`timescale 1ns/1ns

interface retire_if;
    import trace_pkg::*;

    // Retirement strobe and status
    logic      valid;
    xlen_t     insn;
    logic      trap;
    logic      halt;
    xlen_t     pc_rdata;
    xlen_t     pc_wdata;

    // Integer destination
    reg_addr_t rd_addr;
    xlen_t     rd_wdata;

    // Floating-point destination
    logic      frd_wvalid;
    reg_addr_t frd_addr;
    xlen_t     frd_wdata;

    // CSR side effects
    logic      csr_wen;
    xlen_t     csr_wdata;
    xlen_t     mstatus_wmask;
    xlen_t     mstatus_wdata;

    // Driven from the top-level ports
    modport src (
        output valid, insn, trap, halt, pc_rdata, pc_wdata,
        output rd_addr, rd_wdata, frd_wvalid, frd_addr, frd_wdata,
        output csr_wen, csr_wdata, mstatus_wmask, mstatus_wdata
    );

    // Control only needs the strobe and the halt marker
    modport ctrl (
        input valid, halt
    );

    // Datapath fields, never the strobe
    modport dp (
        input insn, trap, pc_rdata, pc_wdata,
        input rd_addr, rd_wdata, frd_wvalid, frd_addr, frd_wdata,
        input csr_wen, csr_wdata, mstatus_wmask, mstatus_wdata
    );

endinterface

/* rtl/rvvi_trace_top.sv */
`timescale 1ns/1ns

module rvvi_trace_top #(
    parameter int unsigned ORDER_W = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Flat retirement record from the core
    input  logic                   retire_valid_i,
    input  trace_pkg::xlen_t       retire_insn_i,
    input  logic                   retire_trap_i,
    input  logic                   retire_halt_i,
    input  trace_pkg::xlen_t       retire_pc_rdata_i,
    input  trace_pkg::xlen_t       retire_pc_wdata_i,
    input  trace_pkg::reg_addr_t   retire_rd_addr_i,
    input  trace_pkg::xlen_t       retire_rd_wdata_i,
    input  logic                   retire_frd_wvalid_i,
    input  trace_pkg::reg_addr_t   retire_frd_addr_i,
    input  trace_pkg::xlen_t       retire_frd_wdata_i,
    input  logic                   retire_csr_wen_i,
    input  trace_pkg::xlen_t       retire_csr_wdata_i,
    input  trace_pkg::xlen_t       retire_mstatus_wmask_i,
    input  trace_pkg::xlen_t       retire_mstatus_wdata_i,
    // Per-register trace for the comparator
    output logic                   rvvi_valid_o,
    output logic [ORDER_W-1:0]     rvvi_order_o,
    output trace_pkg::xlen_t       rvvi_insn_o,
    output logic                   rvvi_trap_o,
    output trace_pkg::xlen_t       rvvi_pc_rdata_o,
    output trace_pkg::xlen_t       rvvi_pc_wdata_o,
    output trace_pkg::reg_flags_t  rvvi_x_wb_o,
    output trace_pkg::xlen_t       rvvi_x_wdata_o,
    output trace_pkg::reg_flags_t  rvvi_f_wb_o,
    output trace_pkg::xlen_t       rvvi_f_wdata_o,
    output trace_pkg::csr_flags_t  rvvi_csr_wb_o,
    output trace_pkg::xlen_t       rvvi_csr_wdata_o,
    output trace_pkg::xlen_t       rvvi_mstatus_wdata_o
);

    logic trace_fire;

    ////////////////////////////////////////
    // Record bundle
    ////////////////////////////////////////

    retire_if rif ();

    assign rif.valid         = retire_valid_i;
    assign rif.insn          = retire_insn_i;
    assign rif.trap          = retire_trap_i;
    assign rif.halt          = retire_halt_i;
    assign rif.pc_rdata      = retire_pc_rdata_i;
    assign rif.pc_wdata      = retire_pc_wdata_i;
    assign rif.rd_addr       = retire_rd_addr_i;
    assign rif.rd_wdata      = retire_rd_wdata_i;
    assign rif.frd_wvalid    = retire_frd_wvalid_i;
    assign rif.frd_addr      = retire_frd_addr_i;
    assign rif.frd_wdata     = retire_frd_wdata_i;
    assign rif.csr_wen       = retire_csr_wen_i;
    assign rif.csr_wdata     = retire_csr_wdata_i;
    assign rif.mstatus_wmask = retire_mstatus_wmask_i;
    assign rif.mstatus_wdata = retire_mstatus_wdata_i;

    ////////////////////////////////////////
    // Control and datapaths
    ////////////////////////////////////////

    trace_ctrl #(
        .ORDER_W ( ORDER_W )
    ) u_ctrl (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .ret_i        ( rif.ctrl     ),
        .trace_fire_o ( trace_fire   ),
        .rvvi_valid_o ( rvvi_valid_o ),
        .rvvi_order_o ( rvvi_order_o )
    );

    // Integer file, x0 never reported
    reg_wb_expand #(
        .SKIP_ZERO ( 1'b1 )
    ) u_x_wb (
        .clk_i   ( clk_i          ),
        .rst_i   ( rst_i          ),
        .fire_i  ( trace_fire     ),
        .wen_i   ( 1'b1           ),
        .addr_i  ( rif.rd_addr    ),
        .wdata_i ( rif.rd_wdata   ),
        .wb_o    ( rvvi_x_wb_o    ),
        .wdata_o ( rvvi_x_wdata_o )
    );

    // FP file, f0 is a real register
    reg_wb_expand #(
        .SKIP_ZERO ( 1'b0 )
    ) u_f_wb (
        .clk_i   ( clk_i          ),
        .rst_i   ( rst_i          ),
        .fire_i  ( trace_fire     ),
        .wen_i   ( rif.frd_wvalid ),
        .addr_i  ( rif.frd_addr   ),
        .wdata_i ( rif.frd_wdata  ),
        .wb_o    ( rvvi_f_wb_o    ),
        .wdata_o ( rvvi_f_wdata_o )
    );

    csr_wb_map u_csr (
        .clk_i           ( clk_i                ),
        .rst_i           ( rst_i                ),
        .fire_i          ( trace_fire           ),
        .ret_i           ( rif.dp               ),
        .csr_wb_o        ( rvvi_csr_wb_o        ),
        .csr_wdata_o     ( rvvi_csr_wdata_o     ),
        .mstatus_wdata_o ( rvvi_mstatus_wdata_o ),
        .insn_o          ( rvvi_insn_o          ),
        .trap_o          ( rvvi_trap_o          ),
        .pc_rdata_o      ( rvvi_pc_rdata_o      ),
        .pc_wdata_o      ( rvvi_pc_wdata_o      )
    );

endmodule

/* rtl/trace_ctrl.sv */
`timescale 1ns/1ns

module trace_ctrl #(
    parameter int unsigned ORDER_W = 64
) (
    input  logic               clk_i,
    input  logic               rst_i,
    retire_if.ctrl             ret_i,
    output logic               trace_fire_o,
    output logic               rvvi_valid_o,
    output logic [ORDER_W-1:0] rvvi_order_o
);
    import trace_pkg::*;

    trace_state_e       state_q;
    trace_state_e       state_d;
    logic               valid_q;
    logic [ORDER_W-1:0] order_q;

    // Capture strobe shared by all datapaths
    // Halted trace drops incoming records
    assign trace_fire_o = ret_i.valid && (state_q != TRACE_HALTED);

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRACE_IDLE: begin
                // First retirement starts the trace
                if (ret_i.valid) begin
                    state_d = TRACE_RUN;
                end
            end
            TRACE_RUN: begin
                state_d = TRACE_RUN;
            end
            default: begin
                state_d = TRACE_HALTED;
            end
        endcase
        // Halt record is traced, then trace stops until reset
        if (ret_i.valid && ret_i.halt) begin
            state_d = TRACE_HALTED;
        end
    end

    ////////////////////////////////////////
    // State, valid pulse, order counter
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= TRACE_IDLE;
            valid_q <= 1'b0;
            order_q <= '0;
        end else begin
            state_q <= state_d;
            valid_q <= trace_fire_o;
            // Order 1 for the first traced record
            if (trace_fire_o) begin
                order_q <= order_q + ORDER_W'(1);
            end
        end
    end

    assign rvvi_valid_o = valid_q;
    assign rvvi_order_o = order_q;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // No output pulse for anything arriving while halted
    a_no_valid_after_halted: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == TRACE_HALTED) |=> !rvvi_valid_o);

    // Order is monotonic between resets
    a_order_monotonic: assert property (@(posedge clk_i) disable iff (rst_i)
        !rst_i |=> (rvvi_order_o >= $past(rvvi_order_o)));

endmodule

/* rtl/trace_pkg.sv */
package trace_pkg;

    ////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////

    // Data word, PC and instruction
    typedef logic [31:0] xlen_t;

    // Register file index
    typedef logic [4:0] reg_addr_t;

    // One writeback flag per architectural register
    typedef logic [31:0] reg_flags_t;

    // CSR address field of a CSR instruction
    typedef logic [11:0] csr_addr_t;

    ////////////////////////////////////////
    // Machine-mode CSR addresses
    ////////////////////////////////////////

    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    // Read-only ID registers
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    ////////////////////////////////////////
    // Tracked CSR table
    ////////////////////////////////////////

    localparam int unsigned NUM_TRACKED_CSR = 10;

    typedef logic [NUM_TRACKED_CSR-1:0] csr_flags_t;

    // Bit position of each tracked CSR in csr_flags_t
    typedef enum logic [3:0] {
        IDX_MSTATUS   = 4'd0,
        IDX_MISA      = 4'd1,
        IDX_MIE       = 4'd2,
        IDX_MTVEC     = 4'd3,
        IDX_MEPC      = 4'd4,
        IDX_MCAUSE    = 4'd5,
        IDX_MVENDORID = 4'd6,
        IDX_MARCHID   = 4'd7,
        IDX_MIMPID    = 4'd8,
        IDX_MHARTID   = 4'd9
    } csr_idx_e;

    // Tracing control FSM
    typedef enum logic [1:0] {
        TRACE_IDLE,
        TRACE_RUN,
        TRACE_HALTED
    } trace_state_e;

endpackage

/* verification/tb_rvvi_trace.sv */
`timescale 1ns/1ns

module tb_rvvi_trace;
    import trace_pkg::*;

    localparam int unsigned ORDER_W        = 64;
    localparam int unsigned NUM_TESTS      = 6;
    localparam int unsigned RESET_CYCLES   = 2;
    localparam int unsigned TIMEOUT_CYCLES = 20 * NUM_TESTS + RESET_CYCLES;

    logic               clk;
    logic               rst;
    logic               retire_valid;
    xlen_t              retire_insn;
    logic               retire_trap;
    logic               retire_halt;
    xlen_t              retire_pc_rdata;
    xlen_t              retire_pc_wdata;
    reg_addr_t          retire_rd_addr;
    xlen_t              retire_rd_wdata;
    logic               retire_frd_wvalid;
    reg_addr_t          retire_frd_addr;
    xlen_t              retire_frd_wdata;
    logic               retire_csr_wen;
    xlen_t              retire_csr_wdata;
    xlen_t              retire_mstatus_wmask;
    xlen_t              retire_mstatus_wdata;

    logic               rvvi_valid;
    logic [ORDER_W-1:0] rvvi_order;
    xlen_t              rvvi_insn;
    logic               rvvi_trap;
    xlen_t              rvvi_pc_rdata;
    xlen_t              rvvi_pc_wdata;
    reg_flags_t         rvvi_x_wb;
    xlen_t              rvvi_x_wdata;
    reg_flags_t         rvvi_f_wb;
    xlen_t              rvvi_f_wdata;
    csr_flags_t         rvvi_csr_wb;
    xlen_t              rvvi_csr_wdata;
    xlen_t              rvvi_mstatus_wdata;

    // Scoreboard state
    logic [ORDER_W-1:0] exp_order;
    logic [31:0]        lfsr_state;
    string              cur_test;
    int unsigned        test_errs;
    int unsigned        pass_cnt;
    int unsigned        fail_cnt;
    int unsigned        cycle_cnt;

    rvvi_trace_top #(
        .ORDER_W ( ORDER_W )
    ) uut (
        .clk_i                  ( clk                  ),
        .rst_i                  ( rst                  ),
        .retire_valid_i         ( retire_valid         ),
        .retire_insn_i          ( retire_insn          ),
        .retire_trap_i          ( retire_trap          ),
        .retire_halt_i          ( retire_halt          ),
        .retire_pc_rdata_i      ( retire_pc_rdata      ),
        .retire_pc_wdata_i      ( retire_pc_wdata      ),
        .retire_rd_addr_i       ( retire_rd_addr       ),
        .retire_rd_wdata_i      ( retire_rd_wdata      ),
        .retire_frd_wvalid_i    ( retire_frd_wvalid    ),
        .retire_frd_addr_i      ( retire_frd_addr      ),
        .retire_frd_wdata_i     ( retire_frd_wdata     ),
        .retire_csr_wen_i       ( retire_csr_wen       ),
        .retire_csr_wdata_i     ( retire_csr_wdata     ),
        .retire_mstatus_wmask_i ( retire_mstatus_wmask ),
        .retire_mstatus_wdata_i ( retire_mstatus_wdata ),
        .rvvi_valid_o           ( rvvi_valid           ),
        .rvvi_order_o           ( rvvi_order           ),
        .rvvi_insn_o            ( rvvi_insn            ),
        .rvvi_trap_o            ( rvvi_trap            ),
        .rvvi_pc_rdata_o        ( rvvi_pc_rdata        ),
        .rvvi_pc_wdata_o        ( rvvi_pc_wdata        ),
        .rvvi_x_wb_o            ( rvvi_x_wb            ),
        .rvvi_x_wdata_o         ( rvvi_x_wdata         ),
        .rvvi_f_wb_o            ( rvvi_f_wb            ),
        .rvvi_f_wdata_o         ( rvvi_f_wdata         ),
        .rvvi_csr_wb_o          ( rvvi_csr_wb          ),
        .rvvi_csr_wdata_o       ( rvvi_csr_wdata       ),
        .rvvi_mstatus_wdata_o   ( rvvi_mstatus_wdata   )
    );

    // 4 ns period
    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    task automatic take_bits(input int n, output xlen_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // csrrw x6, csr, x5
    function automatic xlen_t csr_insn(input csr_addr_t a);
        return {a, 5'd5, 3'b001, 5'd6, 7'h73};
    endfunction

    // Flag vector with only register r marked
    function automatic reg_flags_t flag_at(input reg_addr_t r);
        reg_flags_t f;
        f    = '0;
        f[r] = 1'b1;
        return f;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_flags(input string what, input reg_flags_t exp, input reg_flags_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_csr(input string what, input csr_flags_t exp, input csr_flags_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_word(input string what, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_order(input string what, input logic [ORDER_W-1:0] exp,
                               input logic [ORDER_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    ////////////////////////////////////////
    // Sequencing helpers
    ////////////////////////////////////////

    // Output of the record driven at the previous falling edge
    task automatic step_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic clear_record();
        retire_valid         = 1'b0;
        retire_insn          = '0;
        retire_trap          = 1'b0;
        retire_halt          = 1'b0;
        retire_pc_rdata      = '0;
        retire_pc_wdata      = '0;
        retire_rd_addr       = '0;
        retire_rd_wdata      = '0;
        retire_frd_wvalid    = 1'b0;
        retire_frd_addr      = '0;
        retire_frd_wdata     = '0;
        retire_csr_wen       = 1'b0;
        retire_csr_wdata     = '0;
        retire_mstatus_wmask = '0;
        retire_mstatus_wdata = '0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        clear_record();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        exp_order = '0;
    endtask

    // Traced record: one valid pulse and the next order number
    task automatic expect_traced();
        exp_order = exp_order + 1;
        check_bit("valid", 1'b1, rvvi_valid);
        check_order("order", exp_order, rvvi_order);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            $display("[PASS] %s", cur_test);
            pass_cnt++;
        end else begin
            $display("[DONE] %s with %0d errors", cur_test, test_errs);
            fail_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_and_order();
        start_test("reset_and_order");
        // Idle outputs straight after reset
        check_bit("valid", 1'b0, rvvi_valid);
        check_order("order", '0, rvvi_order);
        check_flags("x_wb", '0, rvvi_x_wb);
        check_flags("f_wb", '0, rvvi_f_wb);
        check_csr("csr_wb", '0, rvvi_csr_wb);
        // Three back-to-back records
        for (int i = 0; i < 3; i++) begin
            retire_valid = 1'b1;
            step_cycle();
            expect_traced();
        end
        clear_record();
        step_cycle();
        check_bit("valid idle", 1'b0, rvvi_valid);
        check_order("order held", exp_order, rvvi_order);
        report_test();
    endtask

    task automatic int_writeback();
        xlen_t     data;
        xlen_t     tmp;
        xlen_t     insn;
        xlen_t     pc;
        reg_addr_t rd;
        start_test("int_writeback");
        rd = '0;
        while (rd == '0) begin
            take_bits(5, tmp);
            rd = reg_addr_t'(tmp);
        end
        take_bits(32, data);
        take_bits(32, insn);
        take_bits(32, pc);
        retire_valid     = 1'b1;
        retire_insn      = insn;
        retire_pc_rdata  = pc;
        retire_pc_wdata  = pc + 32'd4;
        retire_rd_addr   = rd;
        retire_rd_wdata  = data;
        step_cycle();
        expect_traced();
        check_flags("x_wb", flag_at(rd), rvvi_x_wb);
        check_word("x_wdata", data, rvvi_x_wdata);
        check_word("insn", insn, rvvi_insn);
        check_word("pc_rdata", pc, rvvi_pc_rdata);
        check_word("pc_wdata", pc + 32'd4, rvvi_pc_wdata);
        check_bit("trap", 1'b0, rvvi_trap);
        // x0 write is never reported
        retire_rd_addr = '0;
        retire_trap    = 1'b1;
        step_cycle();
        expect_traced();
        check_flags("x_wb x0", '0, rvvi_x_wb);
        check_bit("trap", 1'b1, rvvi_trap);
        clear_record();
        report_test();
    endtask

    task automatic fp_writeback();
        xlen_t     data;
        xlen_t     tmp;
        reg_addr_t fa;
        start_test("fp_writeback");
        // f0 is a real register
        take_bits(32, data);
        retire_valid      = 1'b1;
        retire_frd_wvalid = 1'b1;
        retire_frd_addr   = '0;
        retire_frd_wdata  = data;
        step_cycle();
        expect_traced();
        check_flags("f_wb f0", reg_flags_t'(1), rvvi_f_wb);
        check_word("f_wdata f0", data, rvvi_f_wdata);
        take_bits(5, tmp);
        fa = reg_addr_t'(tmp);
        take_bits(32, data);
        retire_frd_addr  = fa;
        retire_frd_wdata = data;
        step_cycle();
        expect_traced();
        check_flags("f_wb", flag_at(fa), rvvi_f_wb);
        check_word("f_wdata", data, rvvi_f_wdata);
        // Same record, write not valid
        retire_frd_wvalid = 1'b0;
        step_cycle();
        expect_traced();
        check_flags("f_wb off", '0, rvvi_f_wb);
        check_word("f_wdata off", '0, rvvi_f_wdata);
        clear_record();
        report_test();
    endtask

    task automatic csr_table_writes();
        csr_addr_t addr_tab [1:9];
        xlen_t     data;
        start_test("csr_table_writes");
        // Bit positions 1 to 9 of the tracked table
        addr_tab[1] = CSR_MISA;
        addr_tab[2] = CSR_MIE;
        addr_tab[3] = CSR_MTVEC;
        addr_tab[4] = CSR_MEPC;
        addr_tab[5] = CSR_MCAUSE;
        addr_tab[6] = CSR_MVENDORID;
        addr_tab[7] = CSR_MARCHID;
        addr_tab[8] = CSR_MIMPID;
        addr_tab[9] = CSR_MHARTID;
        retire_valid   = 1'b1;
        retire_csr_wen = 1'b1;
        for (int k = 1; k <= 9; k++) begin
            take_bits(32, data);
            retire_insn      = csr_insn(addr_tab[k]);
            retire_csr_wdata = data;
            step_cycle();
            expect_traced();
            check_csr("csr_wb", csr_flags_t'(1) << k, rvvi_csr_wb);
            check_word("csr_wdata", data, rvvi_csr_wdata);
        end
        // Untracked address, mscratch
        retire_insn = csr_insn(12'h340);
        step_cycle();
        expect_traced();
        check_csr("csr_wb untracked", '0, rvvi_csr_wb);
        // mstatus by address alone
        retire_insn = csr_insn(CSR_MSTATUS);
        step_cycle();
        expect_traced();
        check_csr("csr_wb mstatus no mask", '0, rvvi_csr_wb);
        clear_record();
        report_test();
    endtask

    task automatic mstatus_mask();
        xlen_t ms_data;
        xlen_t data;
        start_test("mstatus_mask");
        take_bits(32, ms_data);
        retire_valid         = 1'b1;
        retire_mstatus_wmask = 32'h0000_0088;
        retire_mstatus_wdata = ms_data;
        step_cycle();
        expect_traced();
        check_csr("csr_wb", csr_flags_t'(1), rvvi_csr_wb);
        check_word("mstatus_wdata", ms_data, rvvi_mstatus_wdata);
        // Together with an mepc write
        take_bits(32, data);
        retire_csr_wen   = 1'b1;
        retire_insn      = csr_insn(CSR_MEPC);
        retire_csr_wdata = data;
        step_cycle();
        expect_traced();
        check_csr("csr_wb both", csr_flags_t'(1) | (csr_flags_t'(1) << 4), rvvi_csr_wb);
        check_word("csr_wdata", data, rvvi_csr_wdata);
        check_word("mstatus_wdata", ms_data, rvvi_mstatus_wdata);
        clear_record();
        report_test();
    endtask

    task automatic halt_stops_trace();
        start_test("halt_stops_trace");
        // Halt record itself is traced
        retire_valid   = 1'b1;
        retire_halt    = 1'b1;
        retire_rd_addr = 5'd7;
        step_cycle();
        expect_traced();
        retire_halt = 1'b0;
        for (int i = 0; i < 2; i++) begin
            step_cycle();
            check_bit("valid after halt", 1'b0, rvvi_valid);
            check_order("order after halt", exp_order, rvvi_order);
            check_flags("x_wb after halt", '0, rvvi_x_wb);
        end
        // Fresh reset restarts the count
        apply_reset();
        retire_valid = 1'b1;
        step_cycle();
        expect_traced();
        clear_record();
        step_cycle();
        check_bit("valid idle", 1'b0, rvvi_valid);
        report_test();
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cycle_cnt  = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        test_errs  = 0;
        exp_order  = '0;
        lfsr_state = 32'heeae8add;
        clear_record();
        apply_reset();
        reset_and_order();
        int_writeback();
        fp_writeback();
        csr_table_writes();
        mstatus_mask();
        halt_stops_trace();
        $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
